// ==== design/controlWordGen.sv ====
`timescale 1ns/10ps
`include "mcControl_settings.svh"

module controlWordGen (
    input  mcControlPkg::stage_t      stage,
    input  mcControlPkg::instrClass_t instrClass,
    input  mcControlPkg::aluOp_t      aluFunc,
    output mcControlPkg::ctrlWord_t   ctrl
);
    import mcControlPkg::*;

    always_comb
    begin
        ctrl = '0;
        case (stage)
            STG_IF1, STG_IF2, STG_IF3:
            begin
                ctrl.memRead    = 1'b1;
                ctrl.instrStart = (stage == STG_IF1);
                ctrl.irWrite    = (stage == STG_IF3);
            end
            STG_IF4:
            begin
                ctrl.pcWrite = 1'b1;
                ctrl.aluOp   = `MC_ALU_ADD;
                ctrl.aluSrcB = 2'd1; // pc plus one
            end
            STG_ID:
            begin
                // branch target is parked in aluOut before the compare
                ctrl.aluOp       = `MC_ALU_ADD;
                ctrl.aluSrcB     = 2'd2;
                ctrl.immSel      = 2'd1;
                ctrl.aluOutWrite = (instrClass == CLS_BRANCH);
            end
            STG_EX1, STG_EX2:
            begin
                ctrl.aluOp = aluFunc;
                case (instrClass)
                    CLS_RTYPE:
                    begin
                        ctrl.aluSrcA = 1'b1;
                        if (aluFunc == `MC_ALU_SHL || aluFunc == `MC_ALU_SHR)
                            ctrl.aluSrcB = 2'd1; // shift by one
                    end
                    CLS_IMM, CLS_LOAD, CLS_STORE:
                    begin
                        ctrl.aluSrcA = 1'b1;
                        ctrl.aluSrcB = 2'd2;
                        ctrl.immSel  = 2'd1;
                    end
                    CLS_BRANCH:
                    begin
                        ctrl.aluSrcA  = 1'b1;
                        ctrl.pcSource = 2'd1;
                        if (aluFunc == `MC_ALU_BGZ || aluFunc == `MC_ALU_BLZ)
                            ctrl.aluSrcB = 2'd3; // sign test against zero
                    end
                    CLS_JUMP, CLS_JUMPLINK:
                    begin
                        ctrl.aluSrcB = 2'd2;
                        ctrl.immSel  = 2'd2;
                    end
                    default: // register jumps and wwd pass rs through
                    begin
                        ctrl.aluSrcA = 1'b1;
                        ctrl.aluSrcB = 2'd3;
                    end
                endcase
                if (stage == STG_EX1)
                begin
                    ctrl.pcWrite     = (instrClass == CLS_JUMP || instrClass == CLS_REGJUMP);
                    ctrl.wwdStrobe   = (instrClass == CLS_WWD);
                    ctrl.aluOutWrite = (instrClass == CLS_JUMPLINK ||
                                        instrClass == CLS_REGJUMPLINK);
                end
                else if (instrClass == CLS_BRANCH)
                    ctrl.pcWriteCond = 1'b1;
                else
                    ctrl.aluOutWrite = 1'b1;
            end
            STG_MEM1:
            begin
                ctrl.iorD     = 1'b1;
                ctrl.memRead  = (instrClass == CLS_LOAD);
                ctrl.memWrite = (instrClass == CLS_STORE);
            end
            STG_MEM2:
            begin
                ctrl.iorD     = 1'b1;
                ctrl.mdrWrite = (instrClass == CLS_LOAD);
            end
            STG_WB:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = (instrClass == CLS_LOAD);
                case (instrClass)
                    CLS_RTYPE: ctrl.regDst = 2'd1;
                    CLS_JUMPLINK, CLS_REGJUMPLINK:
                    begin
                        ctrl.regDst   = `MC_LINK_REG;
                        ctrl.pcWrite  = 1'b1; // target waits in aluOut
                        ctrl.pcSource = 2'd1;
                    end
                    default: ctrl.regDst = 2'd0;
                endcase
            end
            default: ctrl = '0; // halt
        endcase

        memExclusive: assert (!(ctrl.memRead && ctrl.memWrite))
            else $error("memRead and memWrite both set in stage %s", stage.name());
        pcExclusive: assert (!(ctrl.pcWrite && ctrl.pcWriteCond))
            else $error("pcWrite and pcWriteCond both set in stage %s", stage.name());
    end

endmodule

// ==== design/instrDecoder.sv ====
`timescale 1ns/10ps
`include "mcControl_settings.svh"

module instrDecoder (
    input  logic                      clk,
    input  logic                      arstN,
    input  mcControlPkg::stage_t      stage,
    input  mcControlPkg::opcode_t     opcode,
    input  mcControlPkg::func_t       func,
    output mcControlPkg::instrClass_t instrClass,
    output mcControlPkg::aluOp_t      aluFunc
);
    import mcControlPkg::*;

    instrClass_t decClass;
    aluOp_t      decAluFunc;
    instrClass_t heldClass;
    aluOp_t      heldAluFunc;

    always_comb
    begin
        decClass = CLS_NOP;
        case (opcode)
            `MC_OP_ADI, `MC_OP_ORI, `MC_OP_LHI: decClass = CLS_IMM;
            `MC_OP_LWD: decClass = CLS_LOAD;
            `MC_OP_SWD: decClass = CLS_STORE;
            `MC_OP_BNE, `MC_OP_BEQ, `MC_OP_BGZ, `MC_OP_BLZ: decClass = CLS_BRANCH;
            `MC_OP_JMP: decClass = CLS_JUMP;
            `MC_OP_JAL: decClass = CLS_JUMPLINK;
            `MC_OP_ALU:
            begin
                case (func)
                    `MC_FUNC_ADD, `MC_FUNC_SUB, `MC_FUNC_AND, `MC_FUNC_ORR,
                    `MC_FUNC_NOT, `MC_FUNC_TCP, `MC_FUNC_SHL, `MC_FUNC_SHR:
                        decClass = CLS_RTYPE;
                    `MC_FUNC_JPR: decClass = CLS_REGJUMP;
                    `MC_FUNC_JRL: decClass = CLS_REGJUMPLINK;
                    `MC_FUNC_WWD: decClass = CLS_WWD;
                    `MC_FUNC_HLT: decClass = CLS_HALT;
                    default: decClass = CLS_NOP; // unknown func
                endcase
            end
            default: decClass = CLS_NOP;
        endcase
    end

    always_comb
    begin
        decAluFunc = `MC_ALU_ADD; // address math, jumps and links
        case (opcode)
            `MC_OP_ORI: decAluFunc = `MC_ALU_ORR;
            `MC_OP_LHI: decAluFunc = `MC_ALU_LHI;
            `MC_OP_BNE: decAluFunc = `MC_ALU_BNE;
            `MC_OP_BEQ: decAluFunc = `MC_ALU_BEQ;
            `MC_OP_BGZ: decAluFunc = `MC_ALU_BGZ;
            `MC_OP_BLZ: decAluFunc = `MC_ALU_BLZ;
            `MC_OP_ALU:
            begin
                case (func)
                    `MC_FUNC_SUB: decAluFunc = `MC_ALU_SUB;
                    `MC_FUNC_AND: decAluFunc = `MC_ALU_AND;
                    `MC_FUNC_ORR: decAluFunc = `MC_ALU_ORR;
                    `MC_FUNC_NOT: decAluFunc = `MC_ALU_NOT;
                    `MC_FUNC_TCP: decAluFunc = `MC_ALU_TCP;
                    `MC_FUNC_SHL: decAluFunc = `MC_ALU_SHL;
                    `MC_FUNC_SHR: decAluFunc = `MC_ALU_SHR;
                    default: decAluFunc = `MC_ALU_ADD;
                endcase
            end
            default: decAluFunc = `MC_ALU_ADD;
        endcase
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            heldClass   <= CLS_NOP;
            heldAluFunc <= `MC_ALU_ADD;
        end
        else if (stage == STG_ID)
        begin
            heldClass   <= decClass; // ir may move on after decode
            heldAluFunc <= decAluFunc;
        end
    end

    assign instrClass = (stage == STG_ID) ? decClass : heldClass;
    assign aluFunc    = (stage == STG_ID) ? decAluFunc : heldAluFunc;

    // the class seen by the sequencer must not drift mid-instruction
    heldClassStable: assert property (@(posedge clk) disable iff (!arstN)
        stage != STG_ID |-> $stable(instrClass))
        else $error("instruction class changed outside ID");

endmodule

// ==== design/mcControl.sv ====
`timescale 1ns/10ps

module mcControl (
    input  logic                    clk,
    input  logic                    arstN,
    input  mcControlPkg::opcode_t   opcode,
    input  mcControlPkg::func_t     func,
    output mcControlPkg::ctrlWord_t ctrl,
    output logic                    halted
);
    import mcControlPkg::*;

    stage_t      stage;
    instrClass_t instrClass;
    aluOp_t      aluFunc;

    instrDecoder decoder_i (
        .clk        (clk),
        .arstN      (arstN),
        .stage      (stage),
        .opcode     (opcode),
        .func       (func),
        .instrClass (instrClass),
        .aluFunc    (aluFunc)
    );

    stageSequencer sequencer_i (
        .clk        (clk),
        .arstN      (arstN),
        .instrClass (instrClass),
        .stage      (stage),
        .halted     (halted)
    );

    controlWordGen ctrlGen_i (
        .stage      (stage),
        .instrClass (instrClass),
        .aluFunc    (aluFunc),
        .ctrl       (ctrl)
    );

endmodule

// ==== design/mcControlPkg.sv ====
`include "mcControl_settings.svh"

package mcControlPkg;

    typedef logic [`MC_OPCODE_W-1:0] opcode_t;
    typedef logic [`MC_FUNC_W-1:0]   func_t;
    typedef logic [`MC_ALUOP_W-1:0]  aluOp_t;
    typedef logic [`MC_SEL_W-1:0]    sel2_t;

    typedef enum logic [3:0] {
        STG_IF1,
        STG_IF2,
        STG_IF3,
        STG_IF4,
        STG_ID,
        STG_EX1,
        STG_EX2,
        STG_MEM1,
        STG_MEM2,
        STG_WB,
        STG_HALT
    } stage_t;

    typedef enum logic [3:0] {
        CLS_NOP,
        CLS_RTYPE,
        CLS_IMM,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JUMP,
        CLS_JUMPLINK,
        CLS_REGJUMP,
        CLS_REGJUMPLINK,
        CLS_WWD,
        CLS_HALT
    } instrClass_t;

    typedef struct packed {
        logic   pcWrite;
        logic   pcWriteCond;
        logic   iorD;
        logic   memRead;
        logic   memWrite;
        logic   memToReg;
        logic   irWrite;
        sel2_t  pcSource;    // 0 alu result, 1 aluOut register
        aluOp_t aluOp;
        logic   aluSrcA;     // 0 pc, 1 register A
        sel2_t  aluSrcB;     // 0 register B, 1 one, 2 immediate, 3 zero
        logic   regWrite;
        sel2_t  regDst;
        sel2_t  immSel;      // 1 sign-extended imm, 2 jump target
        logic   aluOutWrite;
        logic   mdrWrite;
        logic   instrStart;
        logic   wwdStrobe;
    } ctrlWord_t;

endpackage

// ==== design/mcControl_settings.svh ====
`ifndef MC_CONTROL_SETTINGS_SVH
`define MC_CONTROL_SETTINGS_SVH

`define MC_OPCODE_W 4
`define MC_FUNC_W   6
`define MC_ALUOP_W  4
`define MC_SEL_W    2

// opcode field
`define MC_OP_BNE 4'd0
`define MC_OP_BEQ 4'd1
`define MC_OP_BGZ 4'd2
`define MC_OP_BLZ 4'd3
`define MC_OP_ADI 4'd4
`define MC_OP_ORI 4'd5
`define MC_OP_LHI 4'd6
`define MC_OP_LWD 4'd7
`define MC_OP_SWD 4'd8
`define MC_OP_JMP 4'd9
`define MC_OP_JAL 4'd10
`define MC_OP_ALU 4'd15

// func field, only meaningful under MC_OP_ALU
`define MC_FUNC_ADD 6'd0
`define MC_FUNC_SUB 6'd1
`define MC_FUNC_AND 6'd2
`define MC_FUNC_ORR 6'd3
`define MC_FUNC_NOT 6'd4
`define MC_FUNC_TCP 6'd5
`define MC_FUNC_SHL 6'd6
`define MC_FUNC_SHR 6'd7
`define MC_FUNC_JPR 6'd25
`define MC_FUNC_JRL 6'd26
`define MC_FUNC_WWD 6'd28
`define MC_FUNC_HLT 6'd29

// datapath alu function codes
`define MC_ALU_ADD 4'd0
`define MC_ALU_SUB 4'd1
`define MC_ALU_AND 4'd2
`define MC_ALU_ORR 4'd3
`define MC_ALU_NOT 4'd4
`define MC_ALU_TCP 4'd5
`define MC_ALU_SHL 4'd6
`define MC_ALU_SHR 4'd7
`define MC_ALU_LHI 4'd8
`define MC_ALU_BNE 4'd9
`define MC_ALU_BEQ 4'd10
`define MC_ALU_BGZ 4'd11
`define MC_ALU_BLZ 4'd12

`define MC_LINK_REG 2'd2 // regDst code of the link register

`endif

// ==== design/stageSequencer.sv ====
`timescale 1ns/10ps

module stageSequencer (
    input  logic                      clk,
    input  logic                      arstN,
    input  mcControlPkg::instrClass_t instrClass,
    output mcControlPkg::stage_t      stage,
    output logic                      halted
);
    import mcControlPkg::*;

    stage_t nextStage;

    always_comb
    begin
        nextStage = STG_IF1;
        case (stage)
            STG_IF1: nextStage = STG_IF2;
            STG_IF2: nextStage = STG_IF3;
            STG_IF3: nextStage = STG_IF4;
            STG_IF4: nextStage = STG_ID;
            STG_ID:
            begin
                case (instrClass)
                    CLS_NOP:  nextStage = STG_IF1; // unknown codes end here
                    CLS_HALT: nextStage = STG_HALT;
                    default:  nextStage = STG_EX1;
                endcase
            end
            STG_EX1:
            begin
                case (instrClass)
                    CLS_JUMP, CLS_REGJUMP, CLS_WWD: nextStage = STG_IF1;
                    CLS_JUMPLINK, CLS_REGJUMPLINK:  nextStage = STG_WB;
                    default:                        nextStage = STG_EX2;
                endcase
            end
            STG_EX2:
            begin
                case (instrClass)
                    CLS_RTYPE, CLS_IMM:   nextStage = STG_WB;
                    CLS_LOAD, CLS_STORE:  nextStage = STG_MEM1;
                    default:              nextStage = STG_IF1; // branch resolved
                endcase
            end
            STG_MEM1: nextStage = STG_MEM2;
            STG_MEM2: nextStage = (instrClass == CLS_LOAD) ? STG_WB : STG_IF1;
            // reset parks here with halted low, a real halt never leaves
            STG_HALT: nextStage = halted ? STG_HALT : STG_IF1;
            default:  nextStage = STG_IF1; // wb
        endcase
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            stage  <= STG_HALT;
            halted <= 1'b0;
        end
        else
        begin
            stage  <= nextStage;
            halted <= (nextStage == STG_HALT);
        end
    end

    idSuccessor: assert property (@(posedge clk) disable iff (!arstN)
        stage == STG_ID |=>
            (stage == STG_EX1 || stage == STG_IF1 || stage == STG_HALT))
        else $error("ID left to an illegal stage");

endmodule

// ==== mcControl.f ====
+incdir+design
design/mcControlPkg.sv
design/instrDecoder.sv
design/stageSequencer.sv
design/controlWordGen.sv
design/mcControl.sv
tb/mcControlTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the control unit testbench with verilator, run it, grade the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f mcControl.f --top-module mcControlTb \
    > build.log 2>&1 \
    && ./obj_dir/VmcControlTb > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx ">>> PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tb/mcControlTb.sv ====
`timescale 1ns/10ps
`include "mcControl_settings.svh"

module mcControlTb;
    import mcControlPkg::*;

    typedef struct packed {
        opcode_t op;
        func_t   fn;
        int      cycles;   // IF1 to next IF1
        aluOp_t  alu;      // aluOp in EX1
        int      nRd;      // memRead cycles after fetch
        int      nWr;
        int      nRw;
        int      nM2r;
        int      nPwc;
        int      nWwd;
        sel2_t   dst;      // regDst during WB
    } row_t;

    logic      clk = 1'b0;
    logic      arstN;
    opcode_t   opcode;
    func_t     func;
    ctrlWord_t ctrl;
    logic      halted;

    row_t  rows[$];
    string names[$];
    int    order[$];
    int    seed = 32'h4b32;
    int    checks = 0;
    int    valueErrs = 0;
    int    otherErrs = 0;

    mcControl dut_i (
        .clk    (clk),
        .arstN  (arstN),
        .opcode (opcode),
        .func   (func),
        .ctrl   (ctrl),
        .halted (halted)
    );

    always #2 clk = ~clk;

    function automatic void addRow(input string name, input opcode_t op, input func_t fn,
                                   input int cycles, input aluOp_t alu, input int nRd,
                                   input int nWr, input int nRw, input int nM2r,
                                   input int nPwc, input int nWwd, input sel2_t dst);
        row_t row;
        row = '{op, fn, cycles, alu, nRd, nWr, nRw, nM2r, nPwc, nWwd, dst};
        rows.push_back(row);
        names.push_back(name);
    endfunction

    function automatic void buildTable();
        // name  opcode  func  cycles  aluOp  memRd memWr regWr memToReg pcWrCond wwd regDst
        addRow("ADD", `MC_OP_ALU, `MC_FUNC_ADD, 8, `MC_ALU_ADD, 0, 0, 1, 0, 0, 0, 2'd1);
        addRow("SUB", `MC_OP_ALU, `MC_FUNC_SUB, 8, `MC_ALU_SUB, 0, 0, 1, 0, 0, 0, 2'd1);
        addRow("AND", `MC_OP_ALU, `MC_FUNC_AND, 8, `MC_ALU_AND, 0, 0, 1, 0, 0, 0, 2'd1);
        addRow("ORR", `MC_OP_ALU, `MC_FUNC_ORR, 8, `MC_ALU_ORR, 0, 0, 1, 0, 0, 0, 2'd1);
        addRow("NOT", `MC_OP_ALU, `MC_FUNC_NOT, 8, `MC_ALU_NOT, 0, 0, 1, 0, 0, 0, 2'd1);
        addRow("TCP", `MC_OP_ALU, `MC_FUNC_TCP, 8, `MC_ALU_TCP, 0, 0, 1, 0, 0, 0, 2'd1);
        addRow("SHL", `MC_OP_ALU, `MC_FUNC_SHL, 8, `MC_ALU_SHL, 0, 0, 1, 0, 0, 0, 2'd1);
        addRow("SHR", `MC_OP_ALU, `MC_FUNC_SHR, 8, `MC_ALU_SHR, 0, 0, 1, 0, 0, 0, 2'd1);
        addRow("ADI", `MC_OP_ADI, 6'd0, 8, `MC_ALU_ADD, 0, 0, 1, 0, 0, 0, 2'd0);
        addRow("ORI", `MC_OP_ORI, 6'd0, 8, `MC_ALU_ORR, 0, 0, 1, 0, 0, 0, 2'd0);
        addRow("LHI", `MC_OP_LHI, 6'd0, 8, `MC_ALU_LHI, 0, 0, 1, 0, 0, 0, 2'd0);
        addRow("LWD", `MC_OP_LWD, 6'd0, 10, `MC_ALU_ADD, 1, 0, 1, 1, 0, 0, 2'd0);
        addRow("SWD", `MC_OP_SWD, 6'd0, 9, `MC_ALU_ADD, 0, 1, 0, 0, 0, 0, 2'd0);
        addRow("BNE", `MC_OP_BNE, 6'd0, 7, `MC_ALU_BNE, 0, 0, 0, 0, 1, 0, 2'd0);
        addRow("BEQ", `MC_OP_BEQ, 6'd0, 7, `MC_ALU_BEQ, 0, 0, 0, 0, 1, 0, 2'd0);
        addRow("BGZ", `MC_OP_BGZ, 6'd0, 7, `MC_ALU_BGZ, 0, 0, 0, 0, 1, 0, 2'd0);
        addRow("BLZ", `MC_OP_BLZ, 6'd0, 7, `MC_ALU_BLZ, 0, 0, 0, 0, 1, 0, 2'd0);
        addRow("JMP", `MC_OP_JMP, 6'd0, 6, `MC_ALU_ADD, 0, 0, 0, 0, 0, 0, 2'd0);
        addRow("JAL", `MC_OP_JAL, 6'd0, 7, `MC_ALU_ADD, 0, 0, 1, 0, 0, 0, `MC_LINK_REG);
        addRow("JPR", `MC_OP_ALU, `MC_FUNC_JPR, 6, `MC_ALU_ADD, 0, 0, 0, 0, 0, 0, 2'd0);
        addRow("JRL", `MC_OP_ALU, `MC_FUNC_JRL, 7, `MC_ALU_ADD, 0, 0, 1, 0, 0, 0, `MC_LINK_REG);
        addRow("WWD", `MC_OP_ALU, `MC_FUNC_WWD, 6, `MC_ALU_ADD, 0, 0, 0, 0, 0, 1, 2'd0);
        // unknown codes, aluOp sample lands on the next IF1
        addRow("NOP_OP", 4'd11, 6'd0, 5, `MC_ALU_ADD, 0, 0, 0, 0, 0, 0, 2'd0);
        addRow("NOP_FN", `MC_OP_ALU, 6'd40, 5, `MC_ALU_ADD, 0, 0, 0, 0, 0, 0, 2'd0);
        addRow("HLT", `MC_OP_ALU, `MC_FUNC_HLT, 0, `MC_ALU_ADD, 0, 0, 0, 0, 0, 0, 2'd0);
    endfunction

    task automatic checkValue(input string name, input string what, input int expVal,
                              input int gotVal);
        checks++;
        assert (gotVal == expVal)
        else
        begin
            valueErrs++;
            $display("FAIL %s %s: expected %0d, actual %0d", name, what, expVal, gotVal);
        end
    endtask

    task automatic waitStart(output bit ok);
        int t = 0;
        ok = 1'b1;
        while (!ctrl.instrStart)
        begin
            if (t == 20)
            begin
                otherErrs++;
                $display("instrStart did not appear within 20 cycles");
                ok = 1'b0;
                return;
            end
            @(negedge clk);
            t++;
        end
    endtask

    // entered and left at the negedge of an IF1 cycle
    task automatic runInstr(input int r);
        int     cyc = 0;
        int     nRd = 0;
        int     nWr = 0;
        int     nRw = 0;
        int     nM2r = 0;
        int     nPwc = 0;
        int     nWwd = 0;
        aluOp_t exAlu = '0;
        sel2_t  wbDst = '0;
        bit     ok;
        bit     done = 1'b0;
        waitStart(ok);
        if (!ok)
            return;
        while (!done)
        begin
            @(posedge clk);
            #1;
            if (cyc == 0)
            begin
                opcode = rows[r].op;
                func   = rows[r].fn;
            end
            else if (cyc == 4)
            begin
                opcode = opcode_t'($random(seed)); // decoder must hold past ID
                func   = func_t'($random(seed));
            end
            cyc++;
            @(negedge clk);
            if (cyc == 5)
                exAlu = ctrl.aluOp;
            if (ctrl.instrStart)
                done = 1'b1;
            else if (cyc > 12)
            begin
                otherErrs++;
                $display("%s did not return to fetch within 12 cycles", names[r]);
                return;
            end
            else if (cyc >= 4)
            begin
                if (ctrl.memRead) nRd++;
                if (ctrl.memWrite) nWr++;
                if (ctrl.regWrite) nRw++;
                if (ctrl.memToReg) nM2r++;
                if (ctrl.pcWriteCond) nPwc++;
                if (ctrl.wwdStrobe) nWwd++;
                if (ctrl.regWrite) wbDst = ctrl.regDst;
            end
        end
        checkValue(names[r], "cycles", rows[r].cycles, cyc);
        checkValue(names[r], "EX1 aluOp", int'(rows[r].alu), int'(exAlu));
        checkValue(names[r], "memRead cycles", rows[r].nRd, nRd);
        checkValue(names[r], "memWrite cycles", rows[r].nWr, nWr);
        checkValue(names[r], "regWrite cycles", rows[r].nRw, nRw);
        checkValue(names[r], "memToReg cycles", rows[r].nM2r, nM2r);
        checkValue(names[r], "pcWriteCond cycles", rows[r].nPwc, nPwc);
        checkValue(names[r], "wwdStrobe cycles", rows[r].nWwd, nWwd);
        checkValue(names[r], "WB regDst", int'(rows[r].dst), int'(wbDst));
    endtask

    task automatic runHalt(input int r);
        int t = 0;
        bit ok;
        waitStart(ok);
        if (!ok)
            return;
        @(posedge clk);
        #1;
        opcode = rows[r].op;
        func   = rows[r].fn;
        while (!halted)
        begin
            if (t == 10)
            begin
                otherErrs++;
                $display("halted did not rise after %s", names[r]);
                return;
            end
            @(negedge clk);
            t++;
        end
        for (t = 0; t < 20; t++)
        begin
            @(negedge clk);
            checks++;
            assert (halted && ctrl == '0)
            else
            begin
                otherErrs++;
                $display("unit left halt or drove control %0d cycles after halting", t);
            end
        end
    endtask

    initial
    begin
        int i;
        int j;
        int tmp;
        arstN  = 1'b0;
        opcode = '0;
        func   = '0;
        buildTable();
        for (i = 0; i < 5; i++)
        begin
            @(negedge clk);
            checks++;
            assert (ctrl == '0 && halted == 1'b0)
            else
            begin
                otherErrs++;
                $display("control outputs not idle during reset");
            end
        end
        @(posedge clk);
        #1;
        arstN = 1'b1;
        @(posedge clk);
        @(negedge clk);
        checks++;
        assert (ctrl.instrStart)
        else
        begin
            otherErrs++;
            $display("instrStart missing in the first cycle after reset release");
        end
        for (i = 0; i < rows.size() - 1; i++)
            runInstr(i);
        for (i = 0; i < rows.size() - 1; i++)
            order.push_back(i);
        for (i = order.size() - 1; i > 0; i--)
        begin
            j = int'($unsigned($random(seed)) % (i + 1));
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (i = 0; i < order.size(); i++)
            runInstr(order[i]);
        runHalt(rows.size() - 1); // halt always last
        $display("checks %0d, value errors %0d, other errors %0d", checks, valueErrs, otherErrs);
        if (valueErrs == 0 && otherErrs == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
